/* riscv_pipelined.f */
+incdir+source
source/core_pkg.sv
source/stage_if.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/write_back.sv
source/riscv_pipelined.sv
testbench/riscv_pipelined_assert.sv
testbench/riscv_pipelined_tb.sv

/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural register count
`define CORE_NUM_REGS 32

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

/* source/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // rv32i major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    // operand b straight through, for lui
    ALU_PASS_B
  } alu_op_t;

  // what write-back puts into rd
  typedef enum logic [1:0] {
    RES_ALU,
    RES_LOAD,
    RES_LINK
  } result_src_t;

endpackage

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               redirect,
  if_id_if.sink              from_fetch,
  input  logic               wb_we,
  input  core_pkg::reg_idx_t wb_rd,
  input  core_pkg::word_t    wb_data,
  id_ex_if.source            to_execute
);

  logic              valid_q;
  core_pkg::addr_t   pc_q;
  core_pkg::addr_t   pc_plus4_q;
  core_pkg::word_t   instr_q;

  core_pkg::opcode_t opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              known;
  core_pkg::word_t   imm_i;
  core_pkg::word_t   imm_s;
  core_pkg::word_t   imm_b;
  core_pkg::word_t   imm_j;
  core_pkg::word_t   imm_u;
  core_pkg::word_t   rs1_data;
  core_pkg::word_t   rs2_data;

  // if/id register, a taken branch in execute squashes this slot
  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      valid_q <= 1'b0;
      instr_q <= `CORE_NOP;
    end else begin
      valid_q <= from_fetch.valid;
      instr_q <= from_fetch.instr;
    end
    pc_q       <= from_fetch.pc;
    pc_plus4_q <= from_fetch.pc_plus4;
  end

  assign opcode = core_pkg::opcode_t'(instr_q[6:0]);
  assign funct3 = instr_q[14:12];
  assign funct7 = instr_q[31:25];

  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                  instr_q[11:8], 1'b0};
  assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                  instr_q[30:21], 1'b0};
  assign imm_u = {instr_q[31:12], 12'b0};

  register_file u_register_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (instr_q[19:15]),
    .rs2      (instr_q[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),
    .rd       (wb_rd),
    .wd       (wb_data)
  );

  always_comb begin
    known                  = 1'b1;
    to_execute.imm         = imm_i;
    to_execute.alu_op      = core_pkg::ALU_ADD;
    to_execute.alu_src_imm = 1'b0;
    to_execute.mem_read    = 1'b0;
    to_execute.mem_write   = 1'b0;
    to_execute.reg_write   = 1'b0;
    to_execute.result_src  = core_pkg::RES_ALU;
    to_execute.is_branch   = 1'b0;
    to_execute.branch_ne   = 1'b0;
    to_execute.is_jump     = 1'b0;
    case (opcode)
      core_pkg::OP_REG: begin
        to_execute.reg_write = 1'b1;
        case (funct3)
          3'b000:  to_execute.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b010:  to_execute.alu_op = core_pkg::ALU_SLT;
          3'b100:  to_execute.alu_op = core_pkg::ALU_XOR;
          3'b110:  to_execute.alu_op = core_pkg::ALU_OR;
          3'b111:  to_execute.alu_op = core_pkg::ALU_AND;
          default: known = 1'b0;
        endcase
      end
      core_pkg::OP_IMM: begin
        to_execute.reg_write   = 1'b1;
        to_execute.alu_src_imm = 1'b1;
        case (funct3)
          3'b000:  to_execute.alu_op = core_pkg::ALU_ADD;
          3'b100:  to_execute.alu_op = core_pkg::ALU_XOR;
          3'b110:  to_execute.alu_op = core_pkg::ALU_OR;
          3'b111:  to_execute.alu_op = core_pkg::ALU_AND;
          default: known = 1'b0;
        endcase
      end
      core_pkg::OP_LUI: begin
        to_execute.reg_write   = 1'b1;
        to_execute.alu_src_imm = 1'b1;
        to_execute.alu_op      = core_pkg::ALU_PASS_B;
        to_execute.imm         = imm_u;
      end
      core_pkg::OP_LOAD: begin
        // word loads only
        known                  = (funct3 == 3'b010);
        to_execute.reg_write   = 1'b1;
        to_execute.alu_src_imm = 1'b1;
        to_execute.mem_read    = 1'b1;
        to_execute.result_src  = core_pkg::RES_LOAD;
      end
      core_pkg::OP_STORE: begin
        known                  = (funct3 == 3'b010);
        to_execute.alu_src_imm = 1'b1;
        to_execute.mem_write   = 1'b1;
        to_execute.imm         = imm_s;
      end
      core_pkg::OP_BRANCH: begin
        // beq and bne only
        known                = (funct3[2:1] == 2'b00);
        to_execute.is_branch = 1'b1;
        to_execute.branch_ne = funct3[0];
        to_execute.alu_op    = core_pkg::ALU_SUB;
        to_execute.imm       = imm_b;
      end
      core_pkg::OP_JAL: begin
        to_execute.is_jump    = 1'b1;
        to_execute.reg_write  = 1'b1;
        to_execute.result_src = core_pkg::RES_LINK;
        to_execute.imm        = imm_j;
      end
      default: known = 1'b0;
    endcase
  end

  assign to_execute.valid    = valid_q && known;
  assign to_execute.pc       = pc_q;
  assign to_execute.pc_plus4 = pc_plus4_q;
  assign to_execute.rs1_data = rs1_data;
  assign to_execute.rs2_data = rs2_data;
  assign to_execute.rd       = instr_q[11:7];

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic            clk,
  input  logic            reset,
  id_ex_if.sink           from_decode,
  ex_mem_if.source        to_memory,
  output logic            redirect,
  output core_pkg::addr_t redirect_target
);

  logic                  valid_q;
  core_pkg::addr_t       pc_q;
  core_pkg::addr_t       pc_plus4_q;
  core_pkg::word_t       rs1_q;
  core_pkg::word_t       rs2_q;
  core_pkg::word_t       imm_q;
  core_pkg::reg_idx_t    rd_q;
  core_pkg::alu_op_t     alu_op_q;
  logic                  alu_src_imm_q;
  logic                  mem_read_q;
  logic                  mem_write_q;
  logic                  reg_write_q;
  core_pkg::result_src_t result_src_q;
  logic                  is_branch_q;
  logic                  branch_ne_q;
  logic                  is_jump_q;

  core_pkg::word_t       operand_b;
  core_pkg::word_t       alu_result;
  logic                  equal;

  // id/ex register; the slot behind a taken branch is dropped here
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= from_decode.valid && !redirect;
    end
    pc_q          <= from_decode.pc;
    pc_plus4_q    <= from_decode.pc_plus4;
    rs1_q         <= from_decode.rs1_data;
    rs2_q         <= from_decode.rs2_data;
    imm_q         <= from_decode.imm;
    rd_q          <= from_decode.rd;
    alu_op_q      <= from_decode.alu_op;
    alu_src_imm_q <= from_decode.alu_src_imm;
    mem_read_q    <= from_decode.mem_read;
    mem_write_q   <= from_decode.mem_write;
    reg_write_q   <= from_decode.reg_write;
    result_src_q  <= from_decode.result_src;
    is_branch_q   <= from_decode.is_branch;
    branch_ne_q   <= from_decode.branch_ne;
    is_jump_q     <= from_decode.is_jump;
  end

  assign operand_b = alu_src_imm_q ? imm_q : rs2_q;

  always_comb begin
    case (alu_op_q)
      core_pkg::ALU_ADD:    alu_result = rs1_q + operand_b;
      core_pkg::ALU_SUB:    alu_result = rs1_q - operand_b;
      core_pkg::ALU_AND:    alu_result = rs1_q & operand_b;
      core_pkg::ALU_OR:     alu_result = rs1_q | operand_b;
      core_pkg::ALU_XOR:    alu_result = rs1_q ^ operand_b;
      core_pkg::ALU_SLT:    alu_result = {31'b0, $signed(rs1_q) < $signed(operand_b)};
      core_pkg::ALU_PASS_B: alu_result = operand_b;
      default:              alu_result = '0;
    endcase
  end

  // beq wants equal, bne wants not equal
  assign equal           = (rs1_q == rs2_q);
  assign redirect        = valid_q && (is_jump_q || (is_branch_q && (equal != branch_ne_q)));
  assign redirect_target = pc_q + imm_q;

  assign to_memory.valid      = valid_q;
  assign to_memory.alu_result = alu_result;
  assign to_memory.store_data = rs2_q;
  assign to_memory.rd         = rd_q;
  assign to_memory.mem_read   = mem_read_q;
  assign to_memory.mem_write  = mem_write_q;
  assign to_memory.reg_write  = reg_write_q;
  assign to_memory.result_src = result_src_q;
  assign to_memory.pc_plus4   = pc_plus4_q;

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            redirect,
  input  core_pkg::addr_t redirect_target,
  output core_pkg::addr_t imem_address,
  input  core_pkg::word_t imem_read_data,
  if_id_if.source         to_decode
);

  core_pkg::addr_t pc;
  // low for the first cycle out of reset, pc holds meanwhile
  logic            running;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `CORE_RESET_PC;
      running <= 1'b0;
    end else begin
      running <= 1'b1;
      if (redirect) begin
        pc <= redirect_target;
      end else if (running) begin
        pc <= pc + 32'd4;
      end
    end
  end

  assign imem_address = pc;

  // fetched word goes out the same cycle, decode registers it
  assign to_decode.valid    = running;
  assign to_decode.pc       = pc;
  assign to_decode.pc_plus4 = pc + 32'd4;
  assign to_decode.instr    = imem_read_data;

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic            clk,
  input  logic            reset,
  ex_mem_if.sink          from_execute,
  output core_pkg::addr_t dmem_address,
  output core_pkg::word_t dmem_write_data,
  output logic [3:0]      dmem_write_enable,
  input  core_pkg::word_t dmem_read_data,
  mem_wb_if.source        to_write_back
);

  logic                  valid_q;
  core_pkg::word_t       alu_result_q;
  core_pkg::word_t       store_data_q;
  core_pkg::reg_idx_t    rd_q;
  logic                  mem_read_q;
  logic                  mem_write_q;
  logic                  reg_write_q;
  core_pkg::result_src_t result_src_q;
  core_pkg::addr_t       pc_plus4_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= from_execute.valid;
    end
    alu_result_q <= from_execute.alu_result;
    store_data_q <= from_execute.store_data;
    rd_q         <= from_execute.rd;
    mem_read_q   <= from_execute.mem_read;
    mem_write_q  <= from_execute.mem_write;
    reg_write_q  <= from_execute.reg_write;
    result_src_q <= from_execute.result_src;
    pc_plus4_q   <= from_execute.pc_plus4;
  end

  // word stores only, so all four byte lanes together
  assign dmem_address      = alu_result_q;
  assign dmem_write_data   = store_data_q;
  assign dmem_write_enable = {4{valid_q && mem_write_q}};

  assign to_write_back.valid      = valid_q;
  assign to_write_back.alu_result = alu_result_q;
  assign to_write_back.load_data  = mem_read_q ? dmem_read_data : '0;
  assign to_write_back.pc_plus4   = pc_plus4_q;
  assign to_write_back.rd         = rd_q;
  assign to_write_back.reg_write  = reg_write_q;
  assign to_write_back.result_src = result_src_q;

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data,
  input  logic               we,
  input  core_pkg::reg_idx_t rd,
  input  core_pkg::word_t    wd
);

  core_pkg::word_t regs [`CORE_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  // same-cycle write shows up on the read side
  assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

/* source/riscv_pipelined.sv */
`timescale 1ns/1ps

module riscv_pipelined (
  input  logic            clk,
  input  logic            reset,

  // instruction memory
  output core_pkg::addr_t imem_address,
  input  core_pkg::word_t imem_read_data,

  // data memory
  output core_pkg::addr_t dmem_address,
  output core_pkg::word_t dmem_write_data,
  output logic [3:0]      dmem_write_enable,
  input  core_pkg::word_t dmem_read_data
);

  if_id_if  if_id ();
  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  mem_wb_if mem_wb ();

  // branch resolution from execute
  logic               redirect;
  core_pkg::addr_t    redirect_target;

  // register file write port
  logic               wb_we;
  core_pkg::reg_idx_t wb_rd;
  core_pkg::word_t    wb_data;

  fetch_stage u_fetch_stage (
    .clk             (clk),
    .reset           (reset),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .imem_address    (imem_address),
    .imem_read_data  (imem_read_data),
    .to_decode       (if_id)
  );

  decode_stage u_decode_stage (
    .clk        (clk),
    .reset      (reset),
    .redirect   (redirect),
    .from_fetch (if_id),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .to_execute (id_ex)
  );

  execute_stage u_execute_stage (
    .clk             (clk),
    .reset           (reset),
    .from_decode     (id_ex),
    .to_memory       (ex_mem),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

  memory_stage u_memory_stage (
    .clk               (clk),
    .reset             (reset),
    .from_execute      (ex_mem),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data),
    .dmem_write_enable (dmem_write_enable),
    .dmem_read_data    (dmem_read_data),
    .to_write_back     (mem_wb)
  );

  write_back u_write_back (
    .clk         (clk),
    .reset       (reset),
    .from_memory (mem_wb),
    .we          (wb_we),
    .rd          (wb_rd),
    .result      (wb_data)
  );

endmodule

/* source/stage_if.sv */
`timescale 1ns/1ps

// fetch to decode
interface if_id_if;
  logic            valid;
  core_pkg::addr_t pc;
  core_pkg::addr_t pc_plus4;
  core_pkg::word_t instr;

  modport source (output valid, pc, pc_plus4, instr);
  modport sink   (input valid, pc, pc_plus4, instr);
endinterface

// decode to execute, operands plus the full control set
interface id_ex_if;
  logic                  valid;
  core_pkg::addr_t       pc;
  core_pkg::addr_t       pc_plus4;
  core_pkg::word_t       rs1_data;
  core_pkg::word_t       rs2_data;
  core_pkg::word_t       imm;
  core_pkg::reg_idx_t    rd;
  core_pkg::alu_op_t     alu_op;
  logic                  alu_src_imm;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;
  core_pkg::result_src_t result_src;
  logic                  is_branch;
  logic                  branch_ne;
  logic                  is_jump;

  modport source (
    output valid, pc, pc_plus4, rs1_data, rs2_data, imm, rd, alu_op, alu_src_imm,
           mem_read, mem_write, reg_write, result_src, is_branch, branch_ne, is_jump
  );
  modport sink (
    input valid, pc, pc_plus4, rs1_data, rs2_data, imm, rd, alu_op, alu_src_imm,
          mem_read, mem_write, reg_write, result_src, is_branch, branch_ne, is_jump
  );
endinterface

// execute to memory
interface ex_mem_if;
  logic                  valid;
  core_pkg::word_t       alu_result;
  core_pkg::word_t       store_data;
  core_pkg::reg_idx_t    rd;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;
  core_pkg::result_src_t result_src;
  core_pkg::addr_t       pc_plus4;

  modport source (
    output valid, alu_result, store_data, rd, mem_read, mem_write, reg_write,
           result_src, pc_plus4
  );
  modport sink (
    input valid, alu_result, store_data, rd, mem_read, mem_write, reg_write,
          result_src, pc_plus4
  );
endinterface

// memory to write-back
interface mem_wb_if;
  logic                  valid;
  core_pkg::word_t       alu_result;
  core_pkg::word_t       load_data;
  core_pkg::addr_t       pc_plus4;
  core_pkg::reg_idx_t    rd;
  logic                  reg_write;
  core_pkg::result_src_t result_src;

  modport source (output valid, alu_result, load_data, pc_plus4, rd, reg_write, result_src);
  modport sink   (input valid, alu_result, load_data, pc_plus4, rd, reg_write, result_src);
endinterface

/* source/write_back.sv */
`timescale 1ns/1ps

module write_back (
  input  logic               clk,
  input  logic               reset,
  mem_wb_if.sink             from_memory,
  output logic               we,
  output core_pkg::reg_idx_t rd,
  output core_pkg::word_t    result
);

  logic                  valid_q;
  logic                  reg_write_q;
  core_pkg::word_t       alu_result_q;
  core_pkg::word_t       load_data_q;
  core_pkg::addr_t       pc_plus4_q;
  core_pkg::result_src_t result_src_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= from_memory.valid;
    end
    reg_write_q  <= from_memory.reg_write;
    alu_result_q <= from_memory.alu_result;
    load_data_q  <= from_memory.load_data;
    pc_plus4_q   <= from_memory.pc_plus4;
    result_src_q <= from_memory.result_src;
    rd           <= from_memory.rd;
  end

  always_comb begin
    case (result_src_q)
      core_pkg::RES_LOAD: result = load_data_q;
      core_pkg::RES_LINK: result = pc_plus4_q;
      default:            result = alu_result_q;
    endcase
  end

  // x0 writes are dropped here as well
  assign we = valid_q && reg_write_q && (rd != '0);

endmodule

/* testbench/program_input.mem */
// @00 program words (4 per line), @40 the 16 initial data words, @50 the store count,
// then one expected store per line as address and data
@00
06400093 FF900113 123451B7 00002283  // addi x1 100, addi x2 -7, lui x3, lw x5
00402303 00208233 402083B3 0051F433  // lw x6, add, sub, and
04402023 0030E4B3 002345B3 04702223  // sw x4, or, xor, sw x7
04802423 00112633 04902623 04B02823  // sw x8, slt, sw x9, sw x11
0020A6B3 04C02A23 0F02F713 F0036793  // slt, sw x12, andi, ori
04D02C23 5550C813 04E02E23 06F02023  // sw x13, xori, sw x14, sw x15
03708013 07002223 00802883 06002423  // addi x0, sw x16, lw x17, sw x0
00000013 00188913 00000013 00000013  // load value plus one
07202623 00208463 06102823 00109463  // sw x18, beq not taken, sw x1, bne not taken
06202A23 00108663 06102C23 06102E23  // sw x2, beq taken, two squashed stores
00209663 06202C23 06202E23 00C009EF  // bne taken, two squashed stores, jal x19
06302C23 06302E23 00000013 00000013  // two squashed stores
07302C23 0000006F                    // sw link value, halt loop
@40
87654321 0F0F1234 7FFFFFFF 00000000
13579BDF 2468ACE0 DEADBEEF 01020304
A5A5A5A5 5A5A5A5A 0000FFFF FFFF0000
11111111 22222222 33333333 44444444
@50
0000000F
00000040 0000005D  // add
00000044 0000006B  // sub
00000048 02244000  // and with loaded word
0000004C 12345064  // or
00000050 F0F0EDCD  // xor
00000054 00000001  // slt true
00000058 00000000  // slt false
0000005C 00000020  // andi
00000060 FFFFFF34  // ori
00000064 00000531  // xori
00000068 00000000  // x0 after a write to it
0000006C 80000000  // load, add, store back
00000070 00000064  // after beq not taken
00000074 FFFFFFF9  // after bne not taken
00000078 000000B0  // jal link

/* testbench/riscv_pipelined_assert.sv */
`timescale 1ns/1ps

module riscv_pipelined_assert (
  input logic            clk,
  input logic            reset,
  input logic [3:0]      dmem_write_enable,
  input core_pkg::addr_t imem_address
);

  // failed assertions so far
  int violations = 0;

  // pipeline registers are still unknown on the first reset edge
  no_write_in_reset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> (dmem_write_enable == 4'b0000)
  ) else begin
    $error("data memory write enable raised while reset is high");
    violations++;
  end

  // word stores only, so all byte lanes move together
  whole_word_write: assert property (
    @(posedge clk) disable iff (reset)
      (dmem_write_enable == 4'b0000 || dmem_write_enable == 4'b1111)
  ) else begin
    $error("data memory write enable is a partial byte mask");
    violations++;
  end

  fetch_aligned: assert property (
    @(posedge clk) disable iff (reset) (imem_address[1:0] == 2'b00)
  ) else begin
    $error("instruction fetch address is not word aligned");
    violations++;
  end

endmodule

bind riscv_pipelined riscv_pipelined_assert riscv_pipelined_assert_i (
  .clk               (clk),
  .reset             (reset),
  .dmem_write_enable (dmem_write_enable),
  .imem_address      (imem_address)
);

/* testbench/riscv_pipelined_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module riscv_pipelined_tb;

  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 3;
  localparam int PROG_WORDS   = 64;
  localparam int DATA_WORDS   = 16;
  localparam int DMEM_WORDS   = 64;
  localparam int IMAGE_WORDS  = 128;
  // layout of the data file image
  localparam int DATA_BASE    = PROG_WORDS;
  localparam int COUNT_INDEX  = PROG_WORDS + DATA_WORDS;
  localparam int STORE_BASE   = COUNT_INDEX + 1;
  localparam int MAX_STORES   = (IMAGE_WORDS - STORE_BASE) / 2;
  localparam int WATCHDOG_NS  = (PROG_WORDS + 20) * PERIOD_NS;

  logic            clk;
  logic            reset;
  core_pkg::addr_t imem_address;
  core_pkg::word_t imem_read_data;
  core_pkg::addr_t dmem_address;
  core_pkg::word_t dmem_write_data;
  logic [3:0]      dmem_write_enable;
  core_pkg::word_t dmem_read_data;

  core_pkg::word_t image [IMAGE_WORDS];
  core_pkg::word_t dmem [DMEM_WORDS];

  int store_count;
  int stores_seen;
  int value_errors;
  int other_errors;

  riscv_pipelined riscv_pipelined_i (
    .clk               (clk),
    .reset             (reset),
    .imem_address      (imem_address),
    .imem_read_data    (imem_read_data),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data),
    .dmem_write_enable (dmem_write_enable),
    .dmem_read_data    (dmem_read_data)
  );

  always #(PERIOD_NS / 2) clk = ~clk;

  // both memories read combinationally
  assign imem_read_data = image[imem_address[7:2]];
  assign dmem_read_data = dmem[dmem_address[7:2]];

  function automatic core_pkg::word_t expected_address(input int n);
    return image[STORE_BASE + 2 * n];
  endfunction

  function automatic core_pkg::word_t expected_data(input int n);
    return image[STORE_BASE + 2 * n + 1];
  endfunction

  // untouched data words carry their own byte address
  function automatic core_pkg::word_t fill_word(input int index);
    return {16'hc0de, 16'(index * 4)};
  endfunction

  task automatic finish_run();
    int assert_errors;
    assert_errors = riscv_pipelined_i.riscv_pipelined_assert_i.violations;
    $display("summary: %0d value, %0d other, %0d assertion errors; %0d of %0d stores seen",
             value_errors, other_errors, assert_errors, stores_seen, store_count);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // data memory write and store checking
  always @(posedge clk) begin
    if (!reset && dmem_write_enable != 4'b0000) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_write_enable[b]) begin
          dmem[dmem_address[7:2]][8*b +: 8] <= dmem_write_data[8*b +: 8];
        end
      end
      assert (stores_seen < store_count) else begin
        $display("unexpected extra store of %h to address %h at %0t",
                 dmem_write_data, dmem_address, $time);
        other_errors++;
      end
      if (stores_seen < store_count) begin
        assert (dmem_address == expected_address(stores_seen) &&
                dmem_write_data == expected_data(stores_seen)) else begin
          $display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                   stores_seen, dmem_write_data, dmem_address,
                   expected_data(stores_seen), expected_address(stores_seen));
          value_errors++;
        end
      end
      stores_seen++;
    end
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    stores_seen  = 0;
    value_errors = 0;
    other_errors = 0;
    // program words past the end of the file run as nops
    for (int i = 0; i < PROG_WORDS; i++) begin
      image[i] = `CORE_NOP;
    end
    $readmemh("testbench/program_input.mem", image);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = (i < DATA_WORDS) ? image[DATA_BASE + i] : fill_word(i);
    end
    store_count = image[COUNT_INDEX];
    assert (!$isunknown(image[COUNT_INDEX]) && store_count <= MAX_STORES) else begin
      $display("the data file holds no usable store count");
      other_errors++;
      store_count = 0;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // first valid fetch comes one cycle after reset
    @(negedge clk);
    assert (imem_address == `CORE_RESET_PC) else begin
      $display("ERROR %0t: first fetch from %h, expected %h", $time, imem_address,
               `CORE_RESET_PC);
      value_errors++;
    end

    wait (stores_seen >= store_count);
    // a few more cycles to catch stray stores behind the last one
    repeat (8) @(negedge clk);
    finish_run();
  end

  initial begin
    @(negedge reset);
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with only %0d of %0d expected stores seen",
             WATCHDOG_NS, stores_seen, store_count);
    other_errors++;
    finish_run();
  end

endmodule
